//--- hdl/instrMemPkg.sv
`default_nettype none

package instrMemPkg;

	localparam int wordWidth = 32; // instruction and data word
	localparam int pcWidth = 32; // program counter from the core
	localparam int opcodeWidth = 6; // bits 31:26
	localparam int regWidth = 5; // rd, rs, rt fields
	localparam int immWidth = 16; // low half of the word
	localparam int jumpWidth = 26; // bits 25:0

	localparam int bootDepth = 38; // words in the boot program
	localparam int ramDepth = 1024; // program memory words
	localparam int ramAddrWidth = 10; // index into program memory
	localparam int blockSize = 300; // words per process block

	// the cursor needs one more bit than the index so a full memory can be seen
	localparam int cursorWidth = ramAddrWidth + 1;
	localparam int blockStartWidth = wordWidth + 9; // any wdata times blockSize fits

	localparam int axiAddrWidth = 4; // loader register space
	localparam logic [axiAddrWidth-1:0] cursorOffset = 4'h0; // block select
	localparam logic [axiAddrWidth-1:0] dataOffset = 4'h4; // word store

	localparam logic [1:0] respOkay = 2'b00; // axi OKAY
	localparam logic [1:0] respSlvErr = 2'b10; // axi SLVERR

	typedef enum logic [opcodeWidth-1:0] {
		opAdd = 6'b000000,
		opAddi = 6'b000001,
		opSub = 6'b000010,
		opSubi = 6'b000011,
		opMult = 6'b000100,
		opMulti = 6'b000101,
		opDiv = 6'b000110,
		opDivi = 6'b000111,
		opRdiv = 6'b001000, // remainder
		opJ = 6'b010001,
		opJr = 6'b010010,
		opJal = 6'b010011,
		opBeq = 6'b010100,
		opBne = 6'b010101,
		opBlt = 6'b010110,
		opLw = 6'b010111,
		opSw = 6'b011000,
		opMov = 6'b011001,
		opMovi = 6'b011010,
		opMfhi = 6'b011011,
		opMflo = 6'b011100,
		opIn = 6'b011101, // user input
		opOut = 6'b011110, // user output
		opFim = 6'b011111, // end of program
		opScpc = 6'b100001, // save pc context
		opScrg = 6'b100010, // save register context
		opCproc = 6'b100011, // change process
		opEncBios = 6'b100100, // leave boot program
		opLed = 6'b100101,
		opSpc = 6'b100110
	} opcodeT;

	typedef enum logic [1:0] {
		stIdle, // readies up, waiting for a paired beat
		stStore, // accepting cycle, word goes to memory
		stRespond // bvalid held until bready
	} loaderStateT;

endpackage

`default_nettype wire

//--- hdl/bootRom.sv
`timescale 1ns/1ps
`default_nettype none

module bootRom (
	input  logic                              clock,
	input  logic [instrMemPkg::pcWidth-1:0]   pc,
	output logic [instrMemPkg::wordWidth-1:0] romWord
);
	import instrMemPkg::*;

	logic [$clog2(bootDepth)-1:0] romIndex; // low pc bits
	logic inRange; // pc inside the boot program
	logic [wordWidth-1:0] tableWord; // entry for romIndex

	assign romIndex = pc[$clog2(bootDepth)-1:0];
	assign inRange = (pc < bootDepth); // upper pc bits would alias otherwise

	always_comb begin
		case (romIndex)
			0: tableWord = {opCproc, 26'd0}; // run as os process
			1: tableWord = {opMovi, 5'd0, 5'd0, 16'd0}; // r0 = 0
			2: tableWord = {opMovi, 5'd1, 5'd0, 16'd0};
			3: tableWord = {opMovi, 5'd2, 5'd0, 16'd0};
			4: tableWord = {opMovi, 5'd3, 5'd0, 16'd0};
			5: tableWord = {opMovi, 5'd4, 5'd0, 16'd0};
			6: tableWord = {opMovi, 5'd5, 5'd0, 16'd0};
			7: tableWord = {opMovi, 5'd6, 5'd0, 16'd0};
			8: tableWord = {opMovi, 5'd7, 5'd0, 16'd0};
			9: tableWord = {opMovi, 5'd8, 5'd0, 16'd0};
			10: tableWord = {opMovi, 5'd9, 5'd0, 16'd0};
			11: tableWord = {opMovi, 5'd10, 5'd0, 16'd0};
			12: tableWord = {opMovi, 5'd11, 5'd0, 16'd0};
			13: tableWord = {opMovi, 5'd12, 5'd0, 16'd0};
			14: tableWord = {opMovi, 5'd13, 5'd0, 16'd0};
			15: tableWord = {opMovi, 5'd14, 5'd0, 16'd0};
			16: tableWord = {opMovi, 5'd15, 5'd0, 16'd0};
			17: tableWord = {opMovi, 5'd16, 5'd0, 16'd0};
			18: tableWord = {opMovi, 5'd17, 5'd0, 16'd0};
			19: tableWord = {opMovi, 5'd18, 5'd0, 16'd0};
			20: tableWord = {opMovi, 5'd19, 5'd0, 16'd0};
			21: tableWord = {opMovi, 5'd20, 5'd0, 16'd0}; // os scratch regs from here
			22: tableWord = {opMovi, 5'd21, 5'd0, 16'd0};
			23: tableWord = {opMovi, 5'd22, 5'd0, 16'd0};
			24: tableWord = {opMovi, 5'd23, 5'd0, 16'd0};
			25: tableWord = {opMovi, 5'd24, 5'd0, 16'd0};
			26: tableWord = {opMovi, 5'd25, 5'd0, 16'd0};
			27: tableWord = {opMovi, 5'd26, 5'd0, 16'd0};
			28: tableWord = {opMovi, 5'd27, 5'd0, 16'd0};
			29: tableWord = {opMovi, 5'd28, 5'd0, 16'd0};
			30: tableWord = {opMovi, 5'd29, 5'd0, 16'd0};
			31: tableWord = {opMovi, 5'd30, 5'd0, 16'd300}; // r30 = first block
			32: tableWord = {opMovi, 5'd31, 5'd0, 16'd3000}; // r31 = loop limit
			// data memory setup loop, marks each block header
			33: tableWord = {opSw, 5'd0, 5'd30, 5'd30, 11'd1}; // sw r30, 1(r30)
			34: tableWord = {opAddi, 5'd30, 5'd30, 5'd30, 11'd300}; // next block
			35: tableWord = {opBeq, 5'd31, 5'd30, 5'd31, 11'd37}; // done at r31
			36: tableWord = {opJ, 26'd33}; // back to the store
			37: tableWord = {opEncBios, 26'd0}; // hand over to program memory
			default: tableWord = '0; // unused slots up to the index width
		endcase
	end

	always_ff @(posedge clock) begin
		if (inRange) begin
			romWord <= tableWord; // one cycle latency, same as the ram
		end else begin
			romWord <= '0; // past the boot program
		end
	end

endmodule

`default_nettype wire

//--- hdl/programRam.sv
`timescale 1ns/1ps
`default_nettype none

module programRam (
	input  logic                                 clock,
	input  logic                                 writeEnable,
	input  logic [instrMemPkg::ramAddrWidth-1:0] writeIndex,
	input  logic [instrMemPkg::wordWidth-1:0]    writeWord,
	input  logic [instrMemPkg::pcWidth-1:0]      pc,
	output logic [instrMemPkg::wordWidth-1:0]    ramWord
);
	import instrMemPkg::*;

	logic [wordWidth-1:0] mem [ramDepth]; // program words, filled by the loader
	logic inRange; // fetch index inside the array
	logic [ramAddrWidth-1:0] readIndex;

	assign inRange = (pc < ramDepth);
	assign readIndex = pc[ramAddrWidth-1:0]; // only valid with inRange

	always_ff @(posedge clock) begin
		if (writeEnable) begin
			mem[writeIndex] <= writeWord; // loader store port
		end
	end

	// a store and a fetch of the same word on one edge return the old word,
	// the new one shows from the next fetch on
	always_ff @(posedge clock) begin
		if (inRange) begin
			ramWord <= mem[readIndex];
		end else begin
			ramWord <= '0; // fetch past the end
		end
	end

endmodule

`default_nettype wire

//--- hdl/programLoader.sv
`timescale 1ns/1ps
`default_nettype none

module programLoader (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic [instrMemPkg::axiAddrWidth-1:0] awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [instrMemPkg::wordWidth-1:0]    wdata,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	output logic                                 writeEnable,
	output logic [instrMemPkg::ramAddrWidth-1:0] writeIndex,
	output logic [instrMemPkg::wordWidth-1:0]    writeWord
);
	import instrMemPkg::*;

	loaderStateT state; // registered, holds idle or respond
	loaderStateT phase; // what the current cycle does
	logic handshake; // aw and w beats taken together
	logic [cursorWidth-1:0] cursor; // next word to store
	logic [blockStartWidth-1:0] blockStart; // wdata times block size
	logic cursorHit; // address decodes
	logic dataHit;
	logic blockOk; // new block start inside memory
	logic cursorOk; // cursor still inside memory
	logic [1:0] respNext;

	assign awready = (state == stIdle); // low while a response is pending
	assign wready = (state == stIdle);
	assign bvalid = (state == stRespond);
	assign handshake = awvalid && awready && wvalid && wready;

	always_comb begin
		phase = state;
		if (handshake) begin
			phase = stStore; // beat accepted on this edge
		end
	end

	assign cursorHit = (awaddr == cursorOffset);
	assign dataHit = (awaddr == dataOffset);
	assign blockStart = blockStartWidth'(wdata) * blockStartWidth'(blockSize);
	assign blockOk = (blockStart < ramDepth);
	assign cursorOk = (cursor < ramDepth);

	always_comb begin
		respNext = respSlvErr; // unknown offset by default
		if (cursorHit && blockOk) begin
			respNext = respOkay;
		end
		if (dataHit && cursorOk) begin
			respNext = respOkay;
		end
	end

	// store goes out combinationally so the ram writes on the accepting edge
	assign writeEnable = (phase == stStore) && dataHit && cursorOk;
	assign writeIndex = cursor[ramAddrWidth-1:0];
	assign writeWord = wdata;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= stIdle;
			cursor <= '0; // block 0
		end else begin
			case (phase)
				stStore: begin
					state <= stRespond; // bvalid rises with the store
					if (cursorHit && blockOk) begin
						cursor <= cursorWidth'(blockStart); // jump to block start
					end else if (writeEnable) begin
						cursor <= cursor + 1'b1; // next word of the block
					end
				end
				stRespond: begin
					if (bready) begin
						state <= stIdle; // response taken
					end
				end
				default: begin
					state <= stIdle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (phase == stStore) begin
			bresp <= respNext; // held with bvalid
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              endBios,
	input  logic [instrMemPkg::wordWidth-1:0] romWord,
	input  logic [instrMemPkg::wordWidth-1:0] ramWord,
	output logic                              biosRunning,
	output instrMemPkg::opcodeT               opcode,
	output logic [instrMemPkg::regWidth-1:0]  rd,
	output logic [instrMemPkg::regWidth-1:0]  rs,
	output logic [instrMemPkg::regWidth-1:0]  rt,
	output logic [instrMemPkg::immWidth-1:0]  immediate,
	output logic [instrMemPkg::jumpWidth-1:0] jump
);
	import instrMemPkg::*;

	logic romSelected; // source of the word now on romWord/ramWord
	logic [wordWidth-1:0] word; // chosen instruction

	always_ff @(posedge clock) begin
		if (reset) begin
			biosRunning <= 1'b1; // every reset boots again
		end else if (endBios) begin
			biosRunning <= 1'b0; // stays low until reset
		end
	end

	// both memories read at pc on this edge, so the flag is sampled with them
	always_ff @(posedge clock) begin
		if (reset) begin
			romSelected <= 1'b1;
		end else begin
			romSelected <= biosRunning;
		end
	end

	assign word = romSelected ? romWord : ramWord;

	always_comb begin
		opcode = opcodeT'(word[31:26]); // codes outside the set pass through
		rd = word[25:21];
		rs = word[20:16];
		rt = word[15:11]; // overlaps immediate
		immediate = word[15:0];
		jump = word[25:0];
	end

endmodule

`default_nettype wire

//--- hdl/instrMemTop.sv
`timescale 1ns/1ps
`default_nettype none

module instrMemTop (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic [instrMemPkg::pcWidth-1:0]      pc,
	input  logic                                 endBios,
	output logic                                 biosRunning,
	output instrMemPkg::opcodeT                  opcode,
	output logic [instrMemPkg::regWidth-1:0]     rd,
	output logic [instrMemPkg::regWidth-1:0]     rs,
	output logic [instrMemPkg::regWidth-1:0]     rt,
	output logic [instrMemPkg::immWidth-1:0]     immediate,
	output logic [instrMemPkg::jumpWidth-1:0]    jump,
	input  logic [instrMemPkg::axiAddrWidth-1:0] awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [instrMemPkg::wordWidth-1:0]    wdata,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready
);
	import instrMemPkg::*;

	logic [wordWidth-1:0] romWord; // boot rom read data
	logic [wordWidth-1:0] ramWord; // program memory read data
	logic writeEnable; // loader store
	logic [ramAddrWidth-1:0] writeIndex;
	logic [wordWidth-1:0] writeWord;

	bootRom i_bootRom (
		.clock   (clock),
		.pc      (pc),
		.romWord (romWord)
	);

	programRam i_programRam (
		.clock       (clock),
		.writeEnable (writeEnable),
		.writeIndex  (writeIndex),
		.writeWord   (writeWord),
		.pc          (pc),
		.ramWord     (ramWord)
	);

	programLoader i_programLoader (
		.clock       (clock),
		.reset       (reset),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.writeEnable (writeEnable),
		.writeIndex  (writeIndex),
		.writeWord   (writeWord)
	);

	fetchStage i_fetchStage (
		.clock       (clock),
		.reset       (reset),
		.endBios     (endBios),
		.romWord     (romWord),
		.ramWord     (ramWord),
		.biosRunning (biosRunning),
		.opcode      (opcode),
		.rd          (rd),
		.rs          (rs),
		.rt          (rt),
		.immediate   (immediate),
		.jump        (jump)
	);

endmodule

`default_nettype wire

//--- tb/instrMem_sva.sv
`timescale 1ns/1ps
`default_nettype none

module instrMemSva (
	input logic clock,
	input logic reset,
	input logic bvalid,
	input logic bready,
	input logic awready,
	input logic biosRunning
);

	// response stays up until the master takes it
	property bvalidHeld;
		@(posedge clock) disable iff (reset)
			(bvalid && !bready) |=> bvalid;
	endproperty

	// no new address while a response waits
	property awreadyBlocked;
		@(posedge clock) disable iff (reset)
			bvalid |-> !awready;
	endproperty

	// only reset brings the boot program back
	property biosStaysLow;
		@(posedge clock)
			(!reset && !biosRunning) |=> !biosRunning;
	endproperty

	assert property (bvalidHeld) else $error("bvalid dropped before bready");
	assert property (awreadyBlocked) else $error("awready high during a pending response");
	assert property (biosStaysLow) else $error("biosRunning rose without reset");

endmodule

`default_nettype wire

//--- tb/instrMemTb.sv
`timescale 1ns/1ps
`default_nettype none

module instrMemTb;
	import instrMemPkg::*;

	logic clock;
	logic reset;
	logic [pcWidth-1:0] pc;
	logic endBios;
	logic biosRunning;
	opcodeT opcode;
	logic [regWidth-1:0] rd;
	logic [regWidth-1:0] rs;
	logic [regWidth-1:0] rt;
	logic [immWidth-1:0] immediate;
	logic [jumpWidth-1:0] jump;
	logic [axiAddrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [wordWidth-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;

	int errors = 0;
	int checks = 0;
	int testStart = 0; // error count when the current test began
	int waitLimit = 40; // cycles any handshake wait may take
	logic [31:0] lcgState = 32'h7355629f;
	logic [31:0] loaded [8]; // words stored in block 1
	logic [31:0] extraWord; // single words for later tests
	logic [31:0] heldWord;
	logic [1:0] resp;
	int bootPcs [10] = '{0, 1, 31, 32, 33, 34, 35, 36, 37, 40};

	instrMemTop i_instrMemTop (
		.clock(clock), .reset(reset), .pc(pc), .endBios(endBios),
		.biosRunning(biosRunning), .opcode(opcode), .rd(rd), .rs(rs), .rt(rt),
		.immediate(immediate), .jump(jump),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

	bind instrMemTop instrMemSva i_instrMemSva (
		.clock(clock), .reset(reset), .bvalid(bvalid), .bready(bready),
		.awready(awready), .biosRunning(biosRunning)
	);

	always #4 clock = ~clock; // 8 ns period

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// movi style, full 16 bit immediate
	function automatic logic [31:0] immWord(input opcodeT op, input logic [4:0] rdv,
			input logic [4:0] rsv, input logic [15:0] imm);
		return {op, rdv, rsv, imm};
	endfunction

	// rt sits in the top of the immediate, 11 bits left below it
	function automatic logic [31:0] regWord(input opcodeT op, input logic [4:0] rdv,
			input logic [4:0] rsv, input logic [4:0] rtv, input logic [10:0] imm);
		return {op, rdv, rsv, rtv, imm};
	endfunction

	function automatic logic [31:0] bootWord(input int index);
		if (index == 0) return {opCproc, 26'd0};
		if (index == 31) return immWord(opMovi, 5'd30, 5'd0, 16'd300);
		if (index == 32) return immWord(opMovi, 5'd31, 5'd0, 16'd3000);
		if (index >= 1 && index <= 30) return immWord(opMovi, 5'(index - 1), 5'd0, 16'd0);
		if (index == 33) return regWord(opSw, 5'd0, 5'd30, 5'd30, 11'd1);
		if (index == 34) return regWord(opAddi, 5'd30, 5'd30, 5'd30, 11'd300);
		if (index == 35) return regWord(opBeq, 5'd31, 5'd30, 5'd31, 11'd37);
		if (index == 36) return {opJ, 26'd33};
		if (index == 37) return {opEncBios, 26'd0};
		return 32'd0; // past the boot program
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic checkFields(input string name, input logic [31:0] expWord);
		checkValue(name, expWord[31:26], opcode);
		checkValue(name, expWord[25:21], rd);
		checkValue(name, expWord[20:16], rs);
		checkValue(name, expWord[15:11], rt);
		checkValue(name, expWord[15:0], immediate);
		checkValue(name, expWord[25:0], jump);
	endtask

	// pc goes out now, fields are read after the sampling edge
	task automatic fetchCheck(input string name, input int pcValue, input logic [31:0] expWord);
		pc = pcValue;
		@(negedge clock);
		checkFields(name, expWord);
	endtask

	task automatic finishBeat(input string name);
		int waited;
		waited = 0;
		while (!awready && waited < waitLimit) begin
			@(negedge clock);
			waited++;
		end
		if (!awready) begin
			$display("%s: loader never accepted the address and data", name);
			errors++;
		end else begin
			@(posedge clock); // transfer edge
		end
		@(negedge clock);
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic sendBeat(input string name, input logic [3:0] addr, input logic [31:0] data);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		finishBeat(name);
	endtask

	task automatic takeResponse(input string name, output logic [1:0] r);
		int waited;
		waited = 0;
		while (!bvalid && waited < waitLimit) begin
			@(negedge clock);
			waited++;
		end
		if (!bvalid) begin
			$display("%s: no write response arrived", name);
			errors++;
			r = 2'bxx;
		end else begin
			r = bresp;
			bready = 1'b1; // one edge with bready
			@(negedge clock);
			bready = 1'b0;
		end
	endtask

	task automatic axiWrite(input string name, input logic [3:0] addr, input logic [31:0] data,
			input logic [1:0] expResp);
		logic [1:0] r;
		sendBeat(name, addr, data);
		takeResponse(name, r);
		checkValue(name, expResp, r);
	endtask

	task automatic endTest(input string name);
		$display("test %s finished, %0d errors", name, errors - testStart);
		testStart = errors;
	endtask

	task automatic bootFetch();
		checkValue("bootFetch", 1, biosRunning); // set by reset
		foreach (bootPcs[i]) fetchCheck("bootFetch", bootPcs[i], bootWord(bootPcs[i]));
		endTest("bootFetch");
	endtask

	task automatic programLoad();
		axiWrite("programLoad", cursorOffset, 32'd1, respOkay); // block 1 at word 300
		for (int i = 0; i < 8; i++) begin
			lcgState = lcgNext(lcgState);
			loaded[i] = lcgState;
			axiWrite("programLoad", dataOffset, loaded[i], respOkay);
		end
		endTest("programLoad");
	endtask

	task automatic endBoot();
		endBios = 1'b1;
		@(negedge clock);
		endBios = 1'b0;
		checkValue("endBoot", 0, biosRunning);
		for (int i = 0; i < 8; i++) fetchCheck("endBoot", 300 + i, loaded[i]);
		endTest("endBoot");
	endtask

	task automatic blockCursor();
		axiWrite("blockCursor", cursorOffset, 32'd3, respOkay); // word 900
		lcgState = lcgNext(lcgState);
		extraWord = lcgState;
		axiWrite("blockCursor", dataOffset, extraWord, respOkay);
		checkValue("blockCursor", 0, biosRunning); // ram still the source
		fetchCheck("blockCursor", 900, extraWord);
		endTest("blockCursor");
	endtask

	task automatic errorWrites();
		logic [31:0] w;
		axiWrite("errorWrites", 4'h8, 32'h1, respSlvErr); // unmapped offset
		axiWrite("errorWrites", cursorOffset, 32'd4, respSlvErr); // 1200 is past the end
		lcgState = lcgNext(lcgState);
		w = lcgState;
		axiWrite("errorWrites", dataOffset, w, respOkay); // cursor kept at 901
		fetchCheck("errorWrites", 901, w);
		fetchCheck("errorWrites", 900, extraWord);
		endTest("errorWrites");
	endtask

	task automatic backPressure();
		logic [31:0] second;
		lcgState = lcgNext(lcgState);
		heldWord = lcgState;
		lcgState = lcgNext(lcgState);
		second = lcgState;
		sendBeat("backPressure", dataOffset, heldWord); // goes to 902
		awaddr = dataOffset; // next beat waits behind the response
		wdata = second;
		awvalid = 1'b1;
		wvalid = 1'b1;
		repeat (5) begin
			checkValue("backPressure", 1, bvalid);
			checkValue("backPressure", 0, awready);
			checkValue("backPressure", 0, wready); // data channel blocked too
			@(negedge clock);
		end
		checkValue("backPressure", respOkay, bresp);
		bready = 1'b1;
		@(negedge clock);
		bready = 1'b0;
		checkValue("backPressure", 1, wready); // back in idle
		finishBeat("backPressure"); // accepted only now
		takeResponse("backPressure", resp);
		checkValue("backPressure", respOkay, resp);
		fetchCheck("backPressure", 902, heldWord);
		fetchCheck("backPressure", 903, second);
		endTest("backPressure");
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		pc = '0;
		endBios = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		bootFetch();
		programLoad();
		endBoot();
		blockCursor();
		errorWrites();
		backPressure();
		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
hdl/instrMemPkg.sv
hdl/bootRom.sv
hdl/programRam.sv
hdl/programLoader.sv
hdl/fetchStage.sv
hdl/instrMemTop.sv
tb/instrMem_sva.sv
tb/instrMemTb.sv

//--- Bender.yml
package:
  name: instrMem

sources:
  - hdl/instrMemPkg.sv
  - hdl/bootRom.sv
  - hdl/programRam.sv
  - hdl/programLoader.sv
  - hdl/fetchStage.sv
  - hdl/instrMemTop.sv
  - target: test
    files:
      - tb/instrMem_sva.sv
      - tb/instrMemTb.sv
